// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - include_dirs:
      - source
    files:
      - source/cache_types_pkg.sv
      - source/l1_cache.sv
      - source/backing_memory.sv
      - source/cache_subsystem.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/cache_tb.sv

// ==== list.f ====
+incdir+source
+incdir+test
source/cache_types_pkg.sv
source/l1_cache.sv
source/backing_memory.sv
source/cache_subsystem.sv
test/cache_tb.sv

// ==== source/backing_memory.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module backing_memory (
    input  logic                   CLK, nRST,
    input  logic                   ren, wen,
    input  cache_types_pkg::word_t addr, wdata,
    output cache_types_pkg::word_t rdata,
    output logic                   busy
);
    import cache_types_pkg::*;

    localparam int IDX_BITS = $clog2(`MEM_WORDS);
    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 2);  // room for the latency value

    word_t mem [`MEM_WORDS];

    logic [IDX_BITS-1:0] idx;
    logic [CNT_BITS-1:0] wait_cnt;
    logic                req, ready;

    // low word-address bits only, upper bits alias
    assign idx   = addr[2 +: IDX_BITS];
    assign req   = ren || wen;
    assign ready = req && (wait_cnt == CNT_BITS'(`MEM_LATENCY));
    assign busy  = !ready;          // also high while idle
    assign rdata = mem[idx];

    // wait counter, restarts after every completed word
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!req || ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // storage, zero after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen && ready) begin
            mem[idx] <= wdata;      // commit in the busy-low cycle
        end
    end

    // requester never asks both ways
    assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
        else $error("backing memory sees ren and wen together");

endmodule

// ==== source/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_SIZE 1024   // bytes
`define BLOCK_SIZE 2      // words per block, power of two, at most 8
`define ASSOC      2      // 1 = direct mapped, 2 = two way

// everything from here up bypasses the cache
`define NONCACHE_START_ADDR 32'h8000_0000

// backing memory
`define MEM_WORDS   4096  // depth in words, low address bits only
`define MEM_LATENCY 3     // busy cycles before each word completes

`endif

// ==== source/cache_subsystem.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_subsystem (
    input  logic                   CLK, nRST,
    input  logic                   clear, flush,
    output logic                   clear_done, flush_done,
    input  logic                   proc_ren, proc_wen,
    input  cache_types_pkg::word_t proc_addr, proc_wdata,
    output cache_types_pkg::word_t proc_rdata,
    output logic                   proc_busy
);
    import cache_types_pkg::*;

    // memory-side bus between cache and memory
    logic  mem_ren, mem_wen, mem_busy;
    word_t mem_addr, mem_wdata, mem_rdata;

    l1_cache #(
        .CACHE_SIZE         (`CACHE_SIZE),
        .BLOCK_SIZE         (`BLOCK_SIZE),
        .ASSOC              (`ASSOC),
        .NONCACHE_START_ADDR(`NONCACHE_START_ADDR)
    ) u_cache (
        .CLK       (CLK),
        .nRST      (nRST),
        .clear     (clear),
        .flush     (flush),
        .clear_done(clear_done),
        .flush_done(flush_done),
        .proc_ren  (proc_ren),
        .proc_wen  (proc_wen),
        .proc_addr (proc_addr),
        .proc_wdata(proc_wdata),
        .proc_rdata(proc_rdata),
        .proc_busy (proc_busy),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

    // closes the loop behind the cache
    backing_memory u_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .ren  (mem_ren),
        .wen  (mem_wen),
        .addr (mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata),
        .busy (mem_busy)
    );

endmodule

// ==== source/cache_types_pkg.sv ====
package cache_types_pkg;

    // data and address word of both buses
    typedef logic [31:0] word_t;

    // cache controller states
    typedef enum logic [2:0] {
        IDLE,         // tag lookup, hits served here
        FETCH,        // line fill, one word per memory completion
        WB,           // dirty victim going back to memory
        PASS,         // uncached access forwarded to memory
        MAINT_SET,    // walker looks at the current frame
        MAINT_FRAME,  // walker writes back a dirty frame
        MAINT_DONE    // one cycle for the done pulse
    } cache_state_t;

    // which walk is running
    typedef enum logic {
        MAINT_FLUSH,  // keep frames valid
        MAINT_CLEAR   // invalidate every frame
    } maint_op_t;

endpackage

// ==== source/l1_cache.sv ====
`timescale 1ns/1ps

module l1_cache #(
    parameter int CACHE_SIZE = 1024,  // power of two bytes
    parameter int BLOCK_SIZE = 2,     // 2 to 8 words per block
    parameter int ASSOC      = 2,     // 1 or 2
    parameter cache_types_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                   CLK, nRST,
    input  logic                   clear, flush,
    output logic                   clear_done, flush_done,
    input  logic                   proc_ren, proc_wen,
    input  cache_types_pkg::word_t proc_addr, proc_wdata,
    output cache_types_pkg::word_t proc_rdata,
    output logic                   proc_busy,
    output logic                   mem_ren, mem_wen,
    output cache_types_pkg::word_t mem_addr, mem_wdata,
    input  cache_types_pkg::word_t mem_rdata,
    input  logic                   mem_busy
);
    import cache_types_pkg::*;

    localparam int WORD_BITS  = $bits(word_t);
    localparam int BYTE_BITS  = $clog2(WORD_BITS / 8);    // byte offset in a word
    localparam int N_FRAMES   = CACHE_SIZE / (BLOCK_SIZE * WORD_BITS / 8);
    localparam int N_SETS     = N_FRAMES / ASSOC;
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLK_BITS   = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS   = WORD_BITS - SET_BITS - BLK_BITS - BYTE_BITS;
    localparam int FRAME_BITS = (ASSOC > 1) ? $clog2(ASSOC) : 1;

    // frame storage
    word_t               data_q  [N_SETS][ASSOC][BLOCK_SIZE];
    logic [TAG_BITS-1:0] tag_q   [N_SETS][ASSOC];
    logic                valid_q [N_SETS][ASSOC];
    logic                dirty_q [N_SETS][ASSOC];
    logic [FRAME_BITS-1:0] lru_q [N_SETS];     // last used frame of the set

    cache_state_t state, next_state;
    maint_op_t    maint_op_q;

    // walker set and frame counters and the word counter of line transfers
    logic [SET_BITS:0]     set_cnt;
    logic [FRAME_BITS-1:0] frame_cnt;
    logic [BLK_BITS:0]     word_cnt;
    logic [BLK_BITS-1:0]   word_idx;
    logic                  word_inc, word_clr, word_last;
    logic                  walk_step, walk_clr, walk_end;

    // array update strobes
    logic hit_we, lru_we, fill_we, install;
    logic walk_clean, walk_inval, maint_start;

    // processor address split
    logic [TAG_BITS-1:0] addr_tag;
    logic [SET_BITS-1:0] addr_set;
    logic [BLK_BITS-1:0] addr_word;

    assign addr_tag  = proc_addr[WORD_BITS-1 -: TAG_BITS];
    assign addr_set  = proc_addr[BYTE_BITS+BLK_BITS +: SET_BITS];
    assign addr_word = proc_addr[BYTE_BITS +: BLK_BITS];

    logic req, pass_through, hit;
    logic [FRAME_BITS-1:0] hit_frame, victim;
    word_t hit_word;

    assign req          = proc_ren || proc_wen;
    assign pass_through = (proc_addr >= NONCACHE_START_ADDR);

    // search both frames of the set
    always_comb begin
        hit       = 1'b0;
        hit_frame = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (valid_q[addr_set][i] && (tag_q[addr_set][i] == addr_tag)) begin
                hit       = !pass_through;   // uncached region never hits
                hit_frame = FRAME_BITS'(i);
            end
        end
    end

    assign hit_word = data_q[addr_set][hit_frame][addr_word];

    // victim is frame 0 when direct mapped or else the one not used last
    assign victim = (ASSOC == 2) ? ~lru_q[addr_set] : '0;

    logic                victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    assign victim_dirty = valid_q[addr_set][victim] && dirty_q[addr_set][victim];
    assign victim_tag   = tag_q[addr_set][victim];

    // walker view of the current frame
    logic [SET_BITS-1:0] walk_set;
    logic                walk_dirty;
    assign walk_set   = set_cnt[SET_BITS-1:0];
    assign walk_dirty = dirty_q[walk_set][frame_cnt];
    assign walk_end   = (set_cnt == (SET_BITS+1)'(N_SETS));

    assign word_idx  = word_cnt[BLK_BITS-1:0];
    assign word_last = (word_cnt == (BLK_BITS+1)'(BLOCK_SIZE - 1));

    // controller
    always_comb begin
        next_state  = state;
        proc_busy   = 1'b1;        // busy unless a hit or memory says otherwise
        proc_rdata  = hit_word;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        hit_we      = 1'b0;
        lru_we      = 1'b0;
        fill_we     = 1'b0;
        install     = 1'b0;
        walk_clean  = 1'b0;
        walk_inval  = 1'b0;
        maint_start = 1'b0;
        word_inc    = 1'b0;
        word_clr    = 1'b0;
        walk_step   = 1'b0;
        walk_clr    = 1'b0;
        flush_done  = 1'b0;
        clear_done  = 1'b0;

        case (state)
            IDLE: begin
                if (req && pass_through) begin
                    next_state = PASS;
                end else if (req && hit) begin
                    proc_busy = 1'b0;        // hit completes this cycle
                    lru_we    = 1'b1;
                    hit_we    = proc_wen;
                end else if (req) begin
                    next_state = victim_dirty ? WB : FETCH;
                end else if (flush || clear) begin
                    maint_start = 1'b1;
                    walk_clr    = 1'b1;
                    next_state  = MAINT_SET;
                end
            end

            PASS: begin
                mem_ren    = proc_ren;
                mem_wen    = proc_wen;
                mem_addr   = proc_addr;
                mem_wdata  = proc_wdata;
                proc_busy  = mem_busy;       // done with the memory word
                proc_rdata = mem_rdata;
                if (!mem_busy || !req) begin
                    next_state = IDLE;
                end
            end

            WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, addr_set, word_idx, {BYTE_BITS{1'b0}}};
                mem_wdata = data_q[addr_set][victim][word_idx];
                if (!mem_busy) begin
                    if (word_last) begin
                        word_clr   = 1'b1;
                        next_state = FETCH;   // dirty bit goes with the install
                    end else begin
                        word_inc = 1'b1;
                    end
                end
            end

            FETCH: begin
                if (word_cnt == (BLK_BITS+1)'(BLOCK_SIZE)) begin
                    install    = 1'b1;       // tag and valid before going back for the hit
                    word_clr   = 1'b1;
                    next_state = IDLE;
                end else begin
                    mem_ren  = 1'b1;
                    mem_addr = {addr_tag, addr_set, word_idx, {BYTE_BITS{1'b0}}};
                    if (!mem_busy) begin
                        fill_we  = 1'b1;
                        word_inc = 1'b1;
                    end
                end
            end

            MAINT_SET: begin
                if (walk_end) begin
                    next_state = MAINT_DONE;
                end else if (walk_dirty) begin
                    next_state = MAINT_FRAME;
                end else begin
                    walk_inval = (maint_op_q == MAINT_CLEAR);  // clean frame is just dropped
                    walk_step  = 1'b1;
                end
            end

            MAINT_FRAME: begin
                mem_wen   = 1'b1;
                mem_addr  = {tag_q[walk_set][frame_cnt], walk_set, word_idx,
                             {BYTE_BITS{1'b0}}};
                mem_wdata = data_q[walk_set][frame_cnt][word_idx];
                if (!mem_busy) begin
                    if (word_last) begin
                        word_clr   = 1'b1;
                        walk_clean = 1'b1;
                        walk_inval = (maint_op_q == MAINT_CLEAR);
                        walk_step  = 1'b1;
                        next_state = MAINT_SET;
                    end else begin
                        word_inc = 1'b1;
                    end
                end
            end

            MAINT_DONE: begin
                flush_done = (maint_op_q == MAINT_FLUSH);
                clear_done = (maint_op_q == MAINT_CLEAR);
                next_state = IDLE;
            end

            default: next_state = IDLE;
        endcase
    end

    // state, op and counters
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            maint_op_q <= MAINT_FLUSH;
            set_cnt    <= '0;
            frame_cnt  <= '0;
            word_cnt   <= '0;
        end else begin
            state <= next_state;
            if (maint_start) begin
                maint_op_q <= flush ? MAINT_FLUSH : MAINT_CLEAR;  // flush wins a tie
            end
            if (word_clr) begin
                word_cnt <= '0;
            end else if (word_inc) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (walk_clr) begin
                set_cnt   <= '0;
                frame_cnt <= '0;
            end else if (walk_step) begin
                if (frame_cnt == FRAME_BITS'(ASSOC - 1)) begin
                    frame_cnt <= '0;
                    set_cnt   <= set_cnt + 1'b1;   // next set
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // valid, dirty, lru
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                lru_q[s] <= '0;
                for (int f = 0; f < ASSOC; f++) begin
                    valid_q[s][f] <= 1'b0;
                    dirty_q[s][f] <= 1'b0;
                end
            end
        end else begin
            if (lru_we) begin
                lru_q[addr_set] <= hit_frame;
            end
            if (hit_we) begin
                dirty_q[addr_set][hit_frame] <= 1'b1;
            end
            if (install) begin
                valid_q[addr_set][victim] <= 1'b1;
                dirty_q[addr_set][victim] <= 1'b0;   // fresh line matches memory
            end
            if (walk_clean) begin
                dirty_q[walk_set][frame_cnt] <= 1'b0;
            end
            if (walk_inval) begin
                valid_q[walk_set][frame_cnt] <= 1'b0;
            end
        end
    end

    // data words and tags
    always_ff @(posedge CLK) begin
        if (hit_we) begin
            data_q[addr_set][hit_frame][addr_word] <= proc_wdata;
        end
        if (fill_we) begin
            data_q[addr_set][victim][word_idx] <= mem_rdata;
        end
        if (install) begin
            tag_q[addr_set][victim] <= addr_tag;
        end
    end

    // any frame still dirty or valid
    logic any_dirty, any_valid;
    always_comb begin
        any_dirty = 1'b0;
        any_valid = 1'b0;
        for (int s = 0; s < N_SETS; s++) begin
            for (int f = 0; f < ASSOC; f++) begin
                any_dirty = any_dirty || dirty_q[s][f];
                any_valid = any_valid || valid_q[s][f];
            end
        end
    end

    // one memory direction at a time
    assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen both high in %s", state.name());

    // a done pulse lasts one cycle and ends a walk that cleaned every frame
    assert property (@(posedge CLK) disable iff (!nRST)
        (flush_done || clear_done) |-> (!any_dirty && !(clear_done && any_valid))
            ##1 !(flush_done || clear_done))
        else $error("done pulse too long or walk left a frame dirty or valid");

    // requester holds the address across a stall
    assert property (@(posedge CLK) disable iff (!nRST)
        (req && proc_busy) |=> $stable(proc_addr))
        else $error("proc_addr changed while busy");

endmodule

// ==== test/cache_tb_checks.svh ====
`ifndef CACHE_TB_CHECKS_SVH
`define CACHE_TB_CHECKS_SVH

// reference model with one entry per backing memory word
word_t mem_model [`MEM_WORDS];   // what memory must hold
word_t exp_model [`MEM_WORDS];   // what a processor read should return
bit    pending   [`MEM_WORDS];   // cached write not yet back in memory

// upper address bits alias like in the memory
function automatic int mem_idx(word_t addr);
    return int'((addr >> 2) % `MEM_WORDS);
endfunction

task automatic check_word(input string name, input word_t expected, input word_t actual);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("ERROR %s (%s): expected %h, actual %h", cur_test, name, expected, actual);
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("ERROR %s (%s): expected %b, actual %b", cur_test, name, expected, actual);
    end
endtask

// one processor access held until busy is seen low
task automatic bus_access(input logic wr, input word_t addr, input word_t wdata,
                          output word_t rdata, output logic first_busy);
    int           cycles;
    logic         done;
    cache_state_t st;
    cycles     = 0;
    done       = 1'b0;
    rdata      = 'x;
    first_busy = 1'bx;
    proc_ren   = !wr;
    proc_wen   = wr;
    proc_addr  = addr;
    proc_wdata = wdata;
    while (!done && cycles < ACCESS_LIMIT) begin
        @(negedge CLK);               // mid-cycle where outputs have settled
        if (cycles == 0) begin
            first_busy = proc_busy;   // low here means a hit
        end
        if (!proc_busy) begin
            rdata = proc_rdata;
            done  = 1'b1;
        end
        cycles++;
        @(posedge CLK);               // completing edge
        #1;
    end
    proc_ren = 1'b0;
    proc_wen = 1'b0;
    if (!done) begin
        st = uut.u_cache.state;
        n_errors++;
        $display("access to %h did not finish within %0d cycles, cache in %s",
                 addr, ACCESS_LIMIT, st.name());
    end
endtask

task automatic proc_read(input word_t addr, output word_t data, output logic first_busy);
    bus_access(1'b0, addr, '0, data, first_busy);
endtask

task automatic proc_write(input word_t addr, input word_t data, output logic first_busy);
    word_t unused;
    int    i;
    i = mem_idx(addr);
    bus_access(1'b1, addr, data, unused, first_busy);
    exp_model[i] = data;
    if (addr >= `NONCACHE_START_ADDR) begin
        mem_model[i] = data;   // straight to memory
    end else begin
        pending[i] = 1'b1;     // lives in the cache for now
    end
endtask

// all dirty data reaches memory on flush or clear
task automatic commit_pending();
    for (int i = 0; i < `MEM_WORDS; i++) begin
        if (pending[i]) begin
            mem_model[i] = exp_model[i];
            pending[i]   = 1'b0;
        end
    end
endtask

// dirty victim line written back on eviction
task automatic writeback_block(input word_t addr);
    word_t base;
    int    i;
    base = addr & ~word_t'(`BLOCK_SIZE * 4 - 1);
    for (int w = 0; w < `BLOCK_SIZE; w++) begin
        i = mem_idx(base + w * 4);
        if (pending[i]) begin
            mem_model[i] = exp_model[i];
            pending[i]   = 1'b0;
        end
    end
endtask

`endif

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;
    import cache_types_pkg::*;

    localparam int N_FRAMES     = `CACHE_SIZE / (`BLOCK_SIZE * 4);
    localparam int ACCESS_LIMIT = (2 * `BLOCK_SIZE + 2) * (`MEM_LATENCY + 1);  // worst miss
    localparam int MAINT_LIMIT  = N_FRAMES * (`BLOCK_SIZE * (`MEM_LATENCY + 1) + 1) + 4;
    localparam int N_ACCESSES   = 300;  // all tests with the read-back
    localparam int N_WALKS      = 4;    // flushes and clears
    localparam int WATCHDOG_CYCLES = (N_ACCESSES + N_WALKS * N_FRAMES) * ACCESS_LIMIT
                                     + 16 + 2000;
    localparam word_t NC        = `NONCACHE_START_ADDR;

    logic  CLK, nRST, clear, flush, clear_done, flush_done;
    logic  proc_ren, proc_wen, proc_busy;
    word_t proc_addr, proc_wdata, proc_rdata;

    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;
    int n_failed = 0;
    int errors_before = 0;  // error count when the current test began
    string cur_test = "";   // name of the running test

    `include "cache_tb_checks.svh"

    cache_subsystem uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .clear     (clear),
        .flush     (flush),
        .clear_done(clear_done),
        .flush_done(flush_done),
        .proc_ren  (proc_ren),
        .proc_wen  (proc_wen),
        .proc_addr (proc_addr),
        .proc_wdata(proc_wdata),
        .proc_rdata(proc_rdata),
        .proc_busy (proc_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;  // 10 ns period
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic report_test();
        n_tests++;
        if (n_errors == errors_before) begin
            $display("test %0d %s: ok", n_tests, cur_test);
        end else begin
            n_failed++;
            $display("test %0d %s: FAILED, %0d errors", n_tests, cur_test,
                     n_errors - errors_before);
        end
        errors_before = n_errors;
    endtask

    // flush or clear walk with the done pulse checked for width
    task automatic run_walk(input logic use_clear, input string name);
        int           cycles;
        logic         seen, other;
        cache_state_t st;
        cycles = 0;
        seen   = 1'b0;
        other  = 1'b0;
        flush  = !use_clear;
        clear  = use_clear;
        while (!seen && cycles < MAINT_LIMIT) begin
            @(negedge CLK);
            if (use_clear ? clear_done : flush_done) begin
                seen  = 1'b1;
                other = use_clear ? flush_done : clear_done;
            end
            cycles++;
            @(posedge CLK);
            #1;
        end
        flush = 1'b0;  // dropped once the pulse is seen
        clear = 1'b0;
        if (!seen) begin
            st = uut.u_cache.state;
            n_errors++;
            $display("%s gave no done pulse within %0d cycles, cache in %s",
                     name, MAINT_LIMIT, st.name());
        end else begin
            check_bit({name, " other done stays low"}, 1'b0, other);
            @(negedge CLK);
            check_bit({name, " done lasts one cycle"}, 1'b0,
                      use_clear ? clear_done : flush_done);
            @(posedge CLK);
            #1;
        end
        commit_pending();  // every dirty frame went back
    endtask

    task automatic do_flush();
        run_walk(1'b0, "flush");
    endtask

    task automatic do_clear();
        run_walk(1'b1, "clear");
    endtask

    task automatic uncached_access();
        word_t addr, data;
        logic  fb;
        cur_test = "uncached access";
        addr = NC + 32'h0000_0040;
        proc_write(addr, 32'hc0de_0001, fb);
        proc_read(addr, data, fb);
        check_word("uncached read back", mem_model[mem_idx(addr)], data);
        report_test();
    endtask

    task automatic fill_and_hit();
        word_t base, data;
        logic  fb;
        cur_test = "fill and hit";
        base = 32'h0000_0100;                      // set 32
        proc_write(NC | base, 32'h1111_0000, fb);  // preload through the alias
        proc_write(NC | (base + 4), 32'h1111_0004, fb);
        proc_read(base, data, fb);
        check_word("fill word 0", exp_model[mem_idx(base)], data);
        proc_read(base + 4, data, fb);
        check_word("resident word 1", exp_model[mem_idx(base + 4)], data);
        check_bit("word 1 busy in request cycle", 1'b0, fb);
        report_test();
    endtask

    task automatic write_back_flush();
        word_t addr, data;
        logic  fb;
        cur_test = "write-back";
        addr = 32'h0000_0100;
        proc_write(addr, 32'h2222_0100, fb);
        check_bit("write hit busy in request cycle", 1'b0, fb);
        proc_read(NC | addr, data, fb);
        check_word("alias before flush", mem_model[mem_idx(addr)], data);  // still old
        do_flush();
        proc_read(NC | addr, data, fb);
        check_word("alias after flush", mem_model[mem_idx(addr)], data);
        proc_read(addr, data, fb);
        check_word("cached after flush", exp_model[mem_idx(addr)], data);
        report_test();
    endtask

    task automatic evict_lru();
        word_t a, b, c, data;
        logic  fb;
        cur_test = "eviction and LRU";
        a = 32'h0000_0018;  // set 3 with three tags 512 bytes apart
        b = a + 32'h200;
        c = a + 32'h400;
        proc_write(a, 32'h3333_000a, fb);
        proc_write(b, 32'h3333_000b, fb);
        proc_read(a, data, fb);  // a becomes last used
        check_word("first tag touched", exp_model[mem_idx(a)], data);
        proc_write(c, 32'h3333_000c, fb);
        writeback_block(b);      // b was least recently used and dirty
        proc_read(NC | b, data, fb);
        check_word("evicted tag at alias", mem_model[mem_idx(b)], data);
        proc_read(a, data, fb);
        check_word("first tag still cached", exp_model[mem_idx(a)], data);
        if (`ASSOC == 2) begin
            check_bit("first tag busy in request cycle", 1'b0, fb);
        end
        report_test();
    endtask

    task automatic clear_vs_flush();
        word_t addr, data, cached;
        logic  fb;
        int    i;
        cur_test = "clear versus flush";
        addr = 32'h0000_0080;  // set 16
        i    = mem_idx(addr);
        proc_write(addr, 32'h4444_0001, fb);
        do_clear();
        proc_write(NC | addr, 32'h4444_0002, fb);  // memory changes under the line
        proc_read(addr, data, fb);
        check_word("read after clear", exp_model[i], data);
        proc_write(addr, 32'h4444_0003, fb);
        do_flush();
        cached = exp_model[i];
        proc_write(NC | addr, 32'h4444_0004, fb);
        exp_model[i] = cached;  // line stays valid so reads hit the cached copy
        proc_read(addr, data, fb);
        check_word("read after flush", exp_model[i], data);
        report_test();
    endtask

    task automatic random_mix();
        word_t addr, data, wdata;
        word_t touched_q[$];
        bit    touched [`MEM_WORDS];
        logic  fb;
        int    tag, set, word, op;
        cur_test = "random mix";
        for (int n = 0; n < 200; n++) begin
            tag  = $urandom % 4;
            set  = 40 + $urandom % 4;  // sets 40 to 43 not used by earlier tests
            word = $urandom % `BLOCK_SIZE;
            op   = $urandom % 2;
            addr = word_t'(tag * 32'h200 + set * `BLOCK_SIZE * 4 + word * 4);
            if (op == 1) begin
                wdata = $urandom;
                proc_write(addr, wdata, fb);
            end else begin
                proc_read(addr, data, fb);
                check_word($sformatf("random read %h", addr), exp_model[mem_idx(addr)], data);
            end
            if (!touched[mem_idx(addr)]) begin
                touched[mem_idx(addr)] = 1'b1;
                touched_q.push_back(addr);
            end
        end
        do_flush();
        foreach (touched_q[k]) begin
            proc_read(NC | touched_q[k], data, fb);
            check_word($sformatf("read-back %h", touched_q[k]),
                       mem_model[mem_idx(touched_q[k])], data);
        end
        report_test();
    endtask

    initial begin
        void'($urandom(32'h5a9a_e9df));
        nRST       = 1'b0;
        clear      = 1'b0;
        flush      = 1'b0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_model[i] = '0;  // memory is zero after reset
            exp_model[i] = '0;
            pending[i]   = 1'b0;
        end
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;

        uncached_access();
        fill_and_hit();
        write_back_flush();
        evict_lru();
        clear_vs_flush();
        random_mix();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
